//--- vlog.f
common/backend_pkg.sv
rtl/pipe_reg.sv
rtl/reg_files.sv
rtl/stable_counter.sv
dispatch/dispatch.sv
execute/mul_unit.sv
execute/execute.sv
rtl/backend.sv
test/tb_clkgen.sv
test/tb_backend.sv

//--- run.sh
#!/bin/sh
# builds the backend testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_backend -f vlog.f -o tb_backend

out=$(./obj_dir/tb_backend)
printf '%s\n' "$out"

# exit status follows the search for the pass line
echo "$out" | grep -qx "TESTS PASSED"

//--- test/tb_backend.sv
module tb_backend import backend_pkg::*; ();

    localparam int          DRIVE_DLY     = 10;
    localparam logic [15:0] SEED          = 16'd2560;
    localparam int          HS_TIMEOUT    = 500;    // cycles for one input handshake
    localparam int          DRAIN_TIMEOUT = 2000;

    typedef struct packed {
        logic cntl;                                 // low counter half, must grow
        wb_t  wb;
    } expect_t;

    logic            clk;
    logic            rst_n_i;
    logic            uop_valid_i;
    logic            uop_ready_o;
    uop_t            uop_i;
    logic            retire_valid_o;
    logic            retire_ready_i;
    wb_t             retire_o;

    logic [15:0]     lfsr_q;
    logic [XLEN-1:0] model_regs [NREG];
    expect_t         exp_q [$];                     // in program order
    uop_t            cur_uop;
    logic            have_uop;
    logic            bp_on;                         // random retire back-pressure
    logic            timed_out;                     // set once a wait runs out
    logic [XLEN-1:0] last_cntl;
    int              n_checks;
    int              n_errors;
    int              n_accepted;
    int              n_retired;

    tb_clkgen #(
        .PERIOD (100)
    ) u_clkgen (
        .clk_o (clk)
    );

    backend #(
        .MUL_BITS (1)
    ) u_backend (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .uop_valid_i    (uop_valid_i),
        .uop_ready_o    (uop_ready_o),
        .uop_i          (uop_i),
        .retire_valid_o (retire_valid_o),
        .retire_ready_i (retire_ready_i),
        .retire_o       (retire_o)
    );

    // ************************************************************************
    // random source and reference model

    // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] alu_model(
        input alu_op_e         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [2*XLEN-1:0] prod;
        logic [XLEN-1:0]   r;
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_SLL: r = a << b[4:0];
            ALU_SRL: r = a >> b[4:0];
            ALU_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_MUL: r = prod[XLEN-1:0];
            default: r = '0;                        // upper counter half stays zero
        endcase
        return r;
    endfunction

    function automatic uop_t random_uop(input alu_op_e op);
        uop_t u;
        u.op      = op;
        u.rd      = reg_addr_t'(rand_bits(3));      // r0 to r7 only
        u.rj      = reg_addr_t'(rand_bits(3));
        u.rk      = reg_addr_t'(rand_bits(3));
        u.imm     = rand_bits(32);
        u.use_imm = rand_bits(1) != 0;
        u.wen     = rand_bits(3) != 0;
        if (op == ALU_RDCNTL || op == ALU_RDCNTH) begin
            u.wen = 1'b0;                           // counter value is not modelled
        end
        return u;
    endfunction

    task automatic accept_uop(input uop_t u);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        expect_t         e;
        a = (u.rj == '0) ? '0 : model_regs[u.rj];
        b = (u.rk == '0) ? '0 : model_regs[u.rk];
        if (u.use_imm) begin
            b = u.imm;
        end
        e.cntl    = (u.op == ALU_RDCNTL);
        e.wb.rd   = u.rd;
        e.wb.wen  = u.wen;
        e.wb.data = alu_model(u.op, a, b);
        exp_q.push_back(e);
        if (u.wen && u.rd != '0) begin
            model_regs[u.rd] = e.wb.data;
        end
        n_accepted++;
    endtask

    // ************************************************************************
    // checks and report

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_retire();
        expect_t e;
        n_retired++;
        if (exp_q.size() == 0) begin
            n_errors++;
            $display("error at %0t: a result retired with nothing outstanding", $time);
        end else begin
            e = exp_q.pop_front();
            check_value("retire_o.rd", 32'(retire_o.rd), 32'(e.wb.rd));
            check_value("retire_o.wen", 32'(retire_o.wen), 32'(e.wb.wen));
            if (e.cntl) begin
                check_value("rdcntl increase", 32'(retire_o.data > last_cntl), 32'd1);
                last_cntl = retire_o.data;
            end else begin
                check_value("retire_o.data", retire_o.data, e.wb.data);
            end
        end
    endtask

    task automatic report_and_finish();
        $display("%0d checks, %0d errors, %0d accepted, %0d retired",
                 n_checks, n_errors, n_accepted, n_retired);
        if (n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string why);
        n_errors++;
        timed_out = 1'b1;
        $display("error at %0t: %s", $time, why);
    endtask

    task automatic test_done(input int num, input string name, input int errs_before);
        $display("test %0d %s: %s", num, name, (n_errors == errs_before) ? "ok" : "failed");
    endtask

    // ************************************************************************
    // drives one clock and samples both handshakes at the falling edge

    task automatic run_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        uop_valid_i    = have_uop;
        uop_i          = cur_uop;
        retire_ready_i = bp_on ? (rand_bits(2) != 0) : 1'b1;   // low a quarter of the time
        @(negedge clk);
        if (retire_valid_o && retire_ready_i) begin
            check_retire();
        end
        if (uop_valid_i && uop_ready_o) begin
            accept_uop(uop_i);
            have_uop = 1'b0;
        end
    endtask

    task automatic send_uop(input uop_t u);
        int waited;
        if (timed_out) begin
            return;
        end
        cur_uop  = u;
        have_uop = 1'b1;
        waited   = 0;
        while (have_uop && waited < HS_TIMEOUT) begin
            run_cycle();
            waited++;
        end
        if (have_uop) begin
            report_timeout("uop_ready_o stayed low and the operation was never accepted");
        end
    endtask

    task automatic wait_drain();
        int waited;
        if (timed_out) begin
            return;
        end
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            run_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_timeout("accepted operations never retired");
        end
    endtask

    // ************************************************************************
    // test sequence

    initial begin
        uop_t      u;
        reg_addr_t last_rd;
        logic [3:0] opc;
        int        errs;
        int        acc0;
        int        ret0;
        lfsr_q         = SEED;
        rst_n_i        = 1'b0;
        uop_valid_i    = 1'b0;
        uop_i          = '0;
        retire_ready_i = 1'b0;
        cur_uop        = '0;
        have_uop       = 1'b0;
        bp_on          = 1'b0;
        timed_out      = 1'b0;
        last_cntl      = '0;
        n_checks       = 0;
        n_errors       = 0;
        n_accepted     = 0;
        n_retired      = 0;
        for (int i = 0; i < NREG; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst_n_i = 1'b1;

        // reads of r0 and of r8 to r15, which are never written
        errs = n_errors;
        @(negedge clk);
        check_value("retire_valid_o", 32'(retire_valid_o), 32'd0);
        for (int i = 0; i < 8; i++) begin
            u     = '0;
            u.op  = ALU_OR;
            u.rd  = reg_addr_t'(i);
            u.rj  = reg_addr_t'(8 + i);
            u.wen = 1'b1;
            send_uop(u);
        end
        wait_drain();
        test_done(1, "reset state", errs);

        errs = n_errors;
        for (int i = 0; i < 150; i++) begin
            send_uop(random_uop(alu_op_e'(4'(rand_bits(3)))));
        end
        wait_drain();
        test_done(2, "random alu", errs);

        // each op reads the previous destination
        errs    = n_errors;
        bp_on   = 1'b1;
        last_rd = reg_addr_t'(1);
        for (int i = 0; i < 120; i++) begin
            u     = random_uop((rand_bits(2) == 0) ? ALU_MUL : alu_op_e'(4'(rand_bits(3))));
            u.rj  = last_rd;
            u.rk  = (rand_bits(1) != 0) ? last_rd : u.rk;
            u.wen = 1'b1;
            if (u.rd == '0) begin
                u.rd = reg_addr_t'(7);
            end
            last_rd = u.rd;
            send_uop(u);
        end
        wait_drain();
        test_done(3, "dependency chains", errs);

        errs  = n_errors;
        bp_on = 1'b0;
        for (int i = 1; i < 8; i++) begin
            u         = '0;
            u.op      = ALU_ADD;
            u.rd      = reg_addr_t'(i);
            u.imm     = rand_bits(32);
            u.use_imm = 1'b1;
            u.wen     = 1'b1;
            send_uop(u);
        end
        for (int i = 0; i < 40; i++) begin
            send_uop(random_uop(ALU_MUL));
        end
        wait_drain();
        test_done(4, "multiply", errs);

        errs  = n_errors;
        bp_on = 1'b1;
        acc0  = n_accepted;
        ret0  = n_retired;
        for (int i = 0; i < 200; i++) begin
            opc = 4'(rand_bits(4));
            send_uop(random_uop((opc > 4'd10) ? ALU_ADD : alu_op_e'(opc)));
        end
        wait_drain();
        check_value("retired count", 32'(n_retired - ret0), 32'(n_accepted - acc0));
        test_done(5, "retire back-pressure", errs);

        errs = n_errors;
        for (int i = 0; i < 40; i++) begin
            send_uop(random_uop((rand_bits(2) == 0) ? ALU_RDCNTH : ALU_RDCNTL));
        end
        wait_drain();
        test_done(6, "counter reads", errs);

        report_and_finish();
    end

endmodule

//--- test/tb_clkgen.sv
module tb_clkgen #(
    parameter int PERIOD = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

//--- rtl/backend.sv
module backend import backend_pkg::*; #(
    parameter int MUL_BITS = 1
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic uop_valid_i,
    output logic uop_ready_o,
    input  uop_t uop_i,
    output logic retire_valid_o,
    input  logic retire_ready_i,
    output wb_t  retire_o
);

    reg_addr_t       raddr_a;
    reg_addr_t       raddr_b;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    logic            rf_we;
    fwd_t            fwd_ex;
    fwd_t            fwd_wb;
    logic            dsp_valid;             // dispatch -> id_ex
    logic            dsp_ready;
    issue_t          dsp_iss;
    logic            ex_valid;              // id_ex -> execute
    logic            ex_ready;
    issue_t          ex_iss;
    logic            res_valid;             // execute -> ex_wb
    logic            res_ready;
    wb_t             res;
    logic            cnt_hi;
    logic [XLEN-1:0] cnt;

    // ************************************************************************
    // retire writes the register file, ex_wb forwards until then

    assign rf_we  = retire_valid_o & retire_ready_i & retire_o.wen & (retire_o.rd != '0);
    assign fwd_wb = '{
        wen:  retire_valid_o & retire_o.wen,
        rd:   retire_o.rd,
        data: retire_o.data,
        ok:   1'b1
    };

    dispatch u_dispatch (
        .uop_valid_i (uop_valid_i),
        .uop_ready_o (uop_ready_o),
        .uop_i       (uop_i),
        .raddr_a_o   (raddr_a),
        .raddr_b_o   (raddr_b),
        .rdata_a_i   (rdata_a),
        .rdata_b_i   (rdata_b),
        .fwd_ex_i    (fwd_ex),
        .fwd_wb_i    (fwd_wb),
        .iss_valid_o (dsp_valid),
        .iss_ready_i (dsp_ready),
        .iss_o       (dsp_iss)
    );

    reg_files u_reg_files (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .we_i      (rf_we),
        .waddr_i   (retire_o.rd),
        .wdata_i   (retire_o.data)
    );

    pipe_reg #(
        .T (issue_t)
    ) u_id_ex (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (dsp_valid),
        .in_ready_o  (dsp_ready),
        .in_i        (dsp_iss),
        .out_valid_o (ex_valid),
        .out_ready_i (ex_ready),
        .out_o       (ex_iss)
    );

    execute #(
        .MUL_BITS (MUL_BITS)
    ) u_execute (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .iss_valid_i (ex_valid),
        .iss_ready_o (ex_ready),
        .iss_i       (ex_iss),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready),
        .res_o       (res),
        .cnt_i       (cnt),
        .cnt_hi_o    (cnt_hi),
        .fwd_ex_o    (fwd_ex)
    );

    pipe_reg #(
        .T (wb_t)
    ) u_ex_wb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (res_valid),
        .in_ready_o  (res_ready),
        .in_i        (res),
        .out_valid_o (retire_valid_o),
        .out_ready_i (retire_ready_i),
        .out_o       (retire_o)
    );

    stable_counter u_stable_counter (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .hi_sel_i (cnt_hi),
        .count_o  (cnt)
    );

endmodule

//--- execute/execute.sv
module execute import backend_pkg::*; #(
    parameter int MUL_BITS = 1
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            iss_valid_i,
    output logic            iss_ready_o,
    input  issue_t          iss_i,
    output logic            res_valid_o,
    input  logic            res_ready_i,
    output wb_t             res_o,
    input  logic [XLEN-1:0] cnt_i,
    output logic            cnt_hi_o,
    output fwd_t            fwd_ex_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic               is_mul;
    logic               mul_start;
    logic               mul_busy;
    logic               mul_done;
    logic [XLEN-1:0]    mul_prod;
    logic [XLEN-1:0]    src_a;
    logic [XLEN-1:0]    src_b;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    result;

    assign src_a  = iss_i.src_a;
    assign src_b  = iss_i.src_b;
    assign shamt  = src_b[SHAMT_W-1:0];
    assign is_mul = iss_valid_i & (iss_i.op == ALU_MUL);

    // start drops in the cycle the product is taken
    assign mul_start = is_mul & ~(mul_done & res_ready_i);
    assign cnt_hi_o  = (iss_i.op == ALU_RDCNTH);

    // ************************************************************************
    // result select

    always_comb begin
        case (iss_i.op)
            ALU_ADD:    result = src_a + src_b;
            ALU_SUB:    result = src_a - src_b;
            ALU_AND:    result = src_a & src_b;
            ALU_OR:     result = src_a | src_b;
            ALU_XOR:    result = src_a ^ src_b;
            ALU_SLL:    result = src_a << shamt;
            ALU_SRL:    result = src_a >> shamt;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_MUL:    result = mul_prod;
            ALU_RDCNTL: result = cnt_i;
            ALU_RDCNTH: result = cnt_i;         // half picked by cnt_hi_o
            default:    result = '0;
        endcase
    end

    mul_unit #(
        .MUL_BITS (MUL_BITS)
    ) u_mul_unit (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .start_i   (mul_start),
        .a_i       (src_a),
        .b_i       (src_b),
        .busy_o    (mul_busy),
        .done_o    (mul_done),
        .product_o (mul_prod)
    );

    // ************************************************************************
    // handshake and forwarding

    assign res_valid_o = iss_valid_i & (~is_mul | mul_done);
    assign iss_ready_o = res_valid_o & res_ready_i;     // pop when result leaves

    assign res_o = '{rd: iss_i.rd, wen: iss_i.wen, data: result};

    assign fwd_ex_o = '{
        wen:  iss_valid_i & iss_i.wen,
        rd:   iss_i.rd,
        data: result,
        ok:   ~mul_busy                         // product still in flight
    };

endmodule

//--- execute/mul_unit.sv
module mul_unit import backend_pkg::*; #(
    parameter int MUL_BITS = 1
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic            busy_o,
    output logic            done_o,
    output logic [XLEN-1:0] product_o
);

    localparam int MUL_STEPS = (XLEN + MUL_BITS - 1) / MUL_BITS;
    localparam int STEP_W    = $clog2(MUL_STEPS + 1);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e            state_q;
    logic [STEP_W-1:0] step_q;
    logic [XLEN-1:0]   mcand_q;                 // moves left each step
    logic [XLEN-1:0]   mplier_q;                // moves right each step
    logic [XLEN-1:0]   acc_q;
    logic [XLEN-1:0]   partial;

    assign partial = mcand_q * XLEN'(mplier_q[MUL_BITS-1:0]);

    // ************************************************************************
    // sequencer

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        step_q  <= '0;
                    end
                end
                RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == STEP_W'(MUL_STEPS - 1)) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (!start_i) begin
                        state_q <= IDLE;        // result taken
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            mcand_q  <= a_i;
            mplier_q <= b_i;
            acc_q    <= '0;
        end else if (state_q == RUN) begin
            acc_q    <= acc_q + partial;
            mcand_q  <= mcand_q << MUL_BITS;
            mplier_q <= mplier_q >> MUL_BITS;
        end
    end

    assign busy_o    = start_i & (state_q != DONE);     // requested, not ready
    assign done_o    = (state_q == DONE);
    assign product_o = acc_q;

endmodule

//--- dispatch/dispatch.sv
module dispatch import backend_pkg::*; (
    input  logic            uop_valid_i,
    output logic            uop_ready_o,
    input  uop_t            uop_i,
    output reg_addr_t       raddr_a_o,
    output reg_addr_t       raddr_b_o,
    input  logic [XLEN-1:0] rdata_a_i,
    input  logic [XLEN-1:0] rdata_b_i,
    input  fwd_t            fwd_ex_i,
    input  fwd_t            fwd_wb_i,
    output logic            iss_valid_o,
    input  logic            iss_ready_i,
    output issue_t          iss_o
);

    // returns {wait, data}, newest producer wins
    function automatic logic [XLEN:0] resolve(
        input reg_addr_t       addr,
        input logic [XLEN-1:0] rdata,
        input fwd_t            ex,
        input fwd_t            wb
    );
        logic ex_hit;
        logic wb_hit;
        ex_hit = ex.wen && (ex.rd == addr) && (addr != '0);
        wb_hit = wb.wen && (wb.rd == addr) && (addr != '0);
        if (ex_hit) begin
            return {~ex.ok, ex.data};
        end else if (wb_hit) begin
            return {~wb.ok, wb.data};
        end
        return {1'b0, rdata};
    endfunction

    logic [XLEN:0] opnd_a;
    logic [XLEN:0] opnd_b;
    logic          stall;

    assign raddr_a_o = uop_i.rj;
    assign raddr_b_o = uop_i.rk;

    assign opnd_a = resolve(uop_i.rj, rdata_a_i, fwd_ex_i, fwd_wb_i);
    assign opnd_b = resolve(uop_i.rk, rdata_b_i, fwd_ex_i, fwd_wb_i);

    // rk only matters without an immediate
    assign stall = opnd_a[XLEN] | (opnd_b[XLEN] & ~uop_i.use_imm);

    assign iss_valid_o = uop_valid_i & ~stall;
    assign uop_ready_o = iss_ready_i & ~stall;

    assign iss_o = '{
        op:    uop_i.op,
        rd:    uop_i.rd,
        wen:   uop_i.wen,
        src_a: opnd_a[XLEN-1:0],
        src_b: uop_i.use_imm ? uop_i.imm : opnd_b[XLEN-1:0]
    };

endmodule

//--- rtl/stable_counter.sv
module stable_counter import backend_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            hi_sel_i,
    output logic [XLEN-1:0] count_o
);

    logic [2*XLEN-1:0] cnt_q;                   // 64-bit time base

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign count_o = hi_sel_i ? cnt_q[2*XLEN-1:XLEN] : cnt_q[XLEN-1:0];

endmodule

//--- rtl/reg_files.sv
module reg_files import backend_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  reg_addr_t       raddr_a_i,
    input  reg_addr_t       raddr_b_i,
    output logic [XLEN-1:0] rdata_a_o,
    output logic [XLEN-1:0] rdata_b_o,
    input  logic            we_i,
    input  reg_addr_t       waddr_i,
    input  logic [XLEN-1:0] wdata_i
);

    logic [XLEN-1:0] regs_q [NREG];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NREG; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // r0 always reads zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- rtl/pipe_reg.sv
module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic in_valid_i,
    output logic in_ready_o,
    input  T     in_i,
    output logic out_valid_o,
    input  logic out_ready_i,
    output T     out_o
);

    logic valid_q;
    T     data_q;
    logic load;

    assign in_ready_o  = ~valid_q | out_ready_i;    // empty or draining
    assign load        = in_valid_i & in_ready_o;
    assign out_valid_o = valid_q;
    assign out_o       = data_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;                  // refill or go empty
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= in_i;
        end
    end

endmodule

//--- common/backend_pkg.sv
package backend_pkg;

    localparam int XLEN = 32;                   // data path width
    localparam int NREG = 32;                   // architectural registers

    typedef logic [$clog2(NREG)-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SLT    = 4'd7,                      // signed compare
        ALU_MUL    = 4'd8,                      // low half of product
        ALU_RDCNTL = 4'd9,
        ALU_RDCNTH = 4'd10
    } alu_op_e;

    // ************************************************************************
    // stage payloads

    typedef struct packed {
        alu_op_e         op;
        reg_addr_t       rd;                    // destination
        reg_addr_t       rj;                    // first source
        reg_addr_t       rk;                    // second source
        logic [XLEN-1:0] imm;
        logic            use_imm;               // imm replaces rk
        logic            wen;
    } uop_t;

    typedef struct packed {
        alu_op_e         op;
        reg_addr_t       rd;
        logic            wen;
        logic [XLEN-1:0] src_a;
        logic [XLEN-1:0] src_b;
    } issue_t;

    typedef struct packed {
        reg_addr_t       rd;
        logic            wen;
        logic [XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic            wen;
        reg_addr_t       rd;
        logic [XLEN-1:0] data;
        logic            ok;                    // data already valid
    } fwd_t;

endpackage
